// File: rv_core.f
hdl/rv_pkg.sv
hdl/ctrl_if.sv
hdl/controller.sv
hdl/imm_gen.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/branch_unit.sv
hdl/lsu.sv
hdl/rv_core.sv
tests/clk_gen.sv
tests/rv_core_tb.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - files:
      - hdl/rv_pkg.sv
      - hdl/ctrl_if.sv
      - hdl/controller.sv
      - hdl/imm_gen.sv
      - hdl/reg_file.sv
      - hdl/alu.sv
      - hdl/branch_unit.sv
      - hdl/lsu.sv
      - hdl/rv_core.sv
  - target: test
    files:
      - tests/clk_gen.sv
      - tests/rv_core_tb.sv

// File: tests/rv_core_tb.sv
`timescale 1ns/10ps

module rv_core_tb;

    localparam int          NUM_TESTS = 24;
    localparam int          MAX_LEN   = 64;         // Instruction memory words
    localparam logic [31:0] START_PC  = 32'h0000_0000;
    localparam int          DUMP_BASE = 192;        // Register dump area

    logic        clk;
    logic        arst_n;
    logic        rst_req;
    logic [31:0] imem_addr;
    logic [31:0] imem_data;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic [3:0]  dmem_be;
    logic        dmem_wr;
    logic        dmem_rd;
    logic [31:0] dmem_rdata;

    logic [31:0] imem [MAX_LEN];
    logic [31:0] dmem [64];
    logic [31:0] m_regs [32];
    logic [7:0]  m_mem [256];
    logic [31:0] m_pc;
    logic [31:0] seed;
    logic        st_valid;
    logic [31:0] st_addr;
    logic [3:0]  st_be;
    logic [31:0] st_data;
    int          test_errors;
    int          total_errors;
    int          failed_tests;

    clk_gen clk_gen_inst (
        .rst_req (rst_req),
        .clk     (clk),
        .arst_n  (arst_n)
    );

    rv_core #(
        .RESET_PC (START_PC)
    ) rv_core_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_be    (dmem_be),
        .dmem_wr    (dmem_wr),
        .dmem_rd    (dmem_rd),
        .dmem_rdata (dmem_rdata)
    );

    assign imem_data  = imem[imem_addr[7:2]];
    assign dmem_rdata = dmem[dmem_addr[7:2]];

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  be);
        logic [31:0] w;
        w = old_word;
        for (int j = 0; j < 4; j++)
            if (be[j])
                w[8*j +: 8] = new_word[8*j +: 8];
        return w;
    endfunction

    always @(posedge clk)
    begin
        if (dmem_wr)
            dmem[dmem_addr[7:2]] <= merge_bytes(dmem[dmem_addr[7:2]], dmem_wdata, dmem_be);
    end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = next_rand();
        return int'(r[31:16]) % n;  // Upper bits have the longer period
    endfunction

    function automatic logic [31:0] rand_word();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = next_rand();
        lo = next_rand();
        return {hi[31:16], lo[31:16]};
    endfunction

    // Encoders in the base ISA formats
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] random_instr(input int idx, input int body_end);
        int          kind;
        int          f3;
        int          k;
        int          alt;
        int          rs1;
        int          rs2;
        int          rd;
        logic [11:0] imm;
        logic [31:0] w;
        kind = rand_below(10);
        f3   = rand_below(8);
        k    = 1 + rand_below(3);
        alt  = rand_below(2);
        rs1  = 1 + rand_below(15);
        rs2  = 1 + rand_below(15);
        rd   = 1 + rand_below(14);      // x15 keeps the data base
        imm  = rand_word();
        w    = rand_word();
        if (idx + k > body_end)
            k = body_end - idx;         // Forward targets stay in the program
        case (kind)
            0, 1:
                w = enc_r((alt == 1 && (f3 == 0 || f3 == 5)) ? 7'h20 : 7'h00, rs2, rs1, f3, rd);
            2, 3:
            begin
                if (f3 == 1 || f3 == 5)
                    imm[11:5] = (alt == 1 && f3 == 5) ? 7'h20 : 7'h00;
                w = enc_i(imm, rs1, f3, rd, 7'b0010011);
            end
            4:
            begin
                imm = {6'd0, imm[5:0]};     // Prepared region 64..127
                if (f3 == 2)
                    imm[1:0] = 2'b00;
                else if (f3 == 1 || f3 == 5)
                    imm[0] = 1'b0;
                w = enc_i(imm, 5'd15, f3, rd, 7'b0000011);
            end
            5:
            begin
                imm = {6'd1, imm[5:0]};     // Store area 128..191
                f3  = f3 % 4;               // 3 has no width
                if (f3 == 2)
                    imm[1:0] = 2'b00;
                else if (f3 == 1)
                    imm[0] = 1'b0;
                w = enc_s(imm, rs2, 5'd15, f3);
            end
            6:
            begin
                if (f3 == 2 || f3 == 3)
                    f3 = f3 + 4;
                w = enc_b(4 * k, rs2, rs1, f3);
            end
            7:
                w = enc_j(4 * k, rd);
            8:
                w = enc_i(4 * (idx + k) + alt, 5'd0, 3'd0, rd, 7'b1100111);
            default:
            begin
                case (f3 % 4)
                    0:       w[6:0] = 7'b0110111;   // lui
                    1:       w[6:0] = 7'b0010111;   // auipc
                    2:       w[6:0] = 7'b0001111;   // fence
                    default: w[6:0] = 7'b1110011;   // system
                endcase
            end
        endcase
        return w;
    endfunction

    task automatic build_program(output int halt_idx);
        int body_end;
        body_end = 17 + rand_below(25);
        for (int i = 0; i < MAX_LEN; i++)
            imem[i] = 32'd0;
        imem[0] = enc_i(12'd64, 5'd0, 3'd0, 5'd15, 7'b0010011);    // addi x15, x0, 64
        for (int i = 1; i < body_end; i++)
            imem[i] = random_instr(i, body_end);
        for (int r = 1; r <= 15; r++)
            imem[body_end + r - 1] = enc_s(DUMP_BASE + 4 * (r - 1), r, 5'd0, 3'b010);
        halt_idx = body_end + 15;
        imem[halt_idx] = enc_j(21'd0, 5'd0);   // Spin in place
    endtask

    function automatic logic [31:0] model_alu(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        logic signed [31:0] sa;
        sa = a;
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:
            begin
                if (alt)
                    return sa >>> b[4:0];
                return a >> b[4:0];
            end
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic model_branch(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            3'd7:    return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected)
        else
        begin
            $display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            test_errors++;
        end
    endtask

    // Executes one instruction in the ISA model and checks the DUT's memory port
    task automatic model_step();
        logic [31:0] instr;
        logic [2:0]  f3;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] addr;
        logic [31:0] next_pc;
        logic [31:0] result;
        logic [31:0] mask;
        logic        wr_rd;
        logic        ld_valid;
        logic [7:0]  ld0;
        logic [7:0]  ld1;
        logic [7:0]  ld2;
        logic [7:0]  ld3;
        logic [7:0]  base;
        instr   = imem[m_pc[7:2]];
        f3      = instr[14:12];
        a       = m_regs[instr[19:15]];
        b       = m_regs[instr[24:20]];
        imm_i   = {{20{instr[31]}}, instr[31:20]};
        next_pc = m_pc + 32'd4;
        result  = 32'd0;
        addr    = 32'd0;
        wr_rd   = 1'b0;
        ld_valid = 1'b0;
        st_valid = 1'b0;
        st_addr  = 32'd0;
        st_be    = 4'd0;
        st_data  = 32'd0;
        case (instr[6:0])
            7'b0110011:
            begin
                result = model_alu(f3, instr[30], a, b);
                wr_rd  = 1'b1;
            end
            7'b0010011:
            begin
                result = model_alu(f3, f3 == 3'd5 && instr[30], a, imm_i);
                wr_rd  = 1'b1;
            end
            7'b0000011:
            begin
                addr     = a + imm_i;
                ld0      = m_mem[addr[7:0]];
                ld1      = m_mem[addr[7:0] + 8'd1];
                ld2      = m_mem[addr[7:0] + 8'd2];
                ld3      = m_mem[addr[7:0] + 8'd3];
                wr_rd    = 1'b1;
                ld_valid = 1'b1;
                case (f3)
                    3'd0:    result = {{24{ld0[7]}}, ld0};
                    3'd1:    result = {{16{ld1[7]}}, ld1, ld0};
                    3'd2:    result = {ld3, ld2, ld1, ld0};
                    3'd4:    result = {24'd0, ld0};
                    3'd5:    result = {16'd0, ld1, ld0};
                    default:
                    begin
                        wr_rd    = 1'b0;
                        ld_valid = 1'b0;
                    end
                endcase
            end
            7'b0100011:
            begin
                st_addr  = a + {{20{instr[31]}}, instr[31:25], instr[11:7]};
                st_valid = (f3 <= 3'd2);
                case (f3)
                    3'd0:
                    begin
                        st_be   = 4'b0001 << st_addr[1:0];
                        st_data = {24'd0, b[7:0]} << (8 * st_addr[1:0]);
                    end
                    3'd1:
                    begin
                        st_be   = 4'b0011 << st_addr[1:0];
                        st_data = {16'd0, b[15:0]} << (8 * st_addr[1:0]);
                    end
                    3'd2:
                    begin
                        st_be   = 4'b1111;
                        st_data = b;
                    end
                    default: ;
                endcase
            end
            7'b1100011:
            begin
                if (model_branch(f3, a, b))
                    next_pc = m_pc + {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            7'b1101111:
            begin
                result  = m_pc + 32'd4;
                wr_rd   = 1'b1;
                next_pc = m_pc + {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            7'b1100111:
            begin
                result  = m_pc + 32'd4;
                wr_rd   = 1'b1;
                next_pc = (a + imm_i) & ~32'd1;
            end
            default: ;
        endcase
        check_value("dmem_rd", ld_valid, dmem_rd);
        if (ld_valid)
            check_value("dmem_addr", addr, dmem_addr);
        check_value("dmem_wr", st_valid, dmem_wr);
        if (st_valid)
        begin
            mask = {{8{st_be[3]}}, {8{st_be[2]}}, {8{st_be[1]}}, {8{st_be[0]}}};
            check_value("dmem_addr", st_addr, dmem_addr);
            check_value("dmem_be", st_be, dmem_be);
            check_value("dmem_wdata", st_data & mask, dmem_wdata & mask);
            base = {st_addr[7:2], 2'b00};
            for (int j = 0; j < 4; j++)
                if (st_be[j])
                    m_mem[base + j] = st_data[8*j +: 8];
        end
        if (wr_rd && instr[11:7] != 5'd0)
            m_regs[instr[11:7]] = result;
        m_pc = next_pc;
    endtask

    task automatic run_test(input int t);
        int          halt_idx;
        int          steps;
        logic [31:0] halt_pc;
        logic [31:0] first_instr;
        logic        running;
        test_errors = 0;
        @(negedge clk);
        rst_req = 1'b1;
        @(negedge clk);
        rst_req = 1'b0;
        build_program(halt_idx);
        halt_pc     = START_PC + 4 * halt_idx;
        first_instr = imem[0];
        for (int w = 0; w < 64; w++)
        begin
            dmem[w] = rand_word();
            for (int j = 0; j < 4; j++)
                m_mem[4*w + j] = dmem[w][8*j +: 8];
        end
        for (int r = 0; r < 32; r++)
            m_regs[r] = 32'd0;
        m_pc = START_PC;
        // Still in reset with a store or a load at the reset PC
        for (int i = 1; i < 8; i++)
        begin
            check_value("imem_addr", START_PC, imem_addr);
            check_value("dmem_wr", 32'd0, dmem_wr);
            check_value("dmem_rd", 32'd0, dmem_rd);
            if (i == 7)
                imem[0] = first_instr;
            else if (i % 2 == 1)
                imem[0] = enc_s(12'd128, 5'd1, 5'd0, 3'b010);              // sw x1, 128(x0)
            else
                imem[0] = enc_i(12'd64, 5'd0, 3'b010, 5'd1, 7'b0000011);   // lw x1, 64(x0)
            @(negedge clk);
        end
        steps   = 0;
        running = 1'b1;
        while (running)
        begin
            check_value("imem_addr", m_pc, imem_addr);
            assert (imem_addr <= halt_pc)
            else
            begin
                $display("Error at %0t ns: PC %h left the program", $time, imem_addr);
                test_errors++;
            end
            if (m_pc == halt_pc || steps >= MAX_LEN)
                running = 1'b0;
            else
            begin
                model_step();
                steps++;
                @(negedge clk);
            end
        end
        total_errors += test_errors;
        if (test_errors != 0)
            failed_tests++;
        $display("Test %0d: %0d instructions, %0d errors", t, steps, test_errors);
    endtask

    initial
    begin
        seed         = 32'h832b_9a09;
        rst_req      = 1'b0;
        total_errors = 0;
        failed_tests = 0;
        for (int i = 0; i < MAX_LEN; i++)
            imem[i] = 32'd0;
        for (int i = 0; i < 64; i++)
            dmem[i] = 32'd0;
        for (int t = 0; t < NUM_TESTS; t++)
            run_test(t);
        $display("Tests: %0d, failed: %0d, errors: %0d", NUM_TESTS, failed_tests, total_errors);
        if (total_errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

    // Twice the worst case of all programs at one instruction per cycle
    initial
    begin
        #(NUM_TESTS * MAX_LEN * 20 * 2);
        $display("Error: watchdog expired before the tests finished");
        $display("Done: errors found");
        $finish;
    end

endmodule

// File: tests/clk_gen.sv
`timescale 1ns/10ps

module clk_gen (
    input  logic rst_req,
    output logic clk,
    output logic arst_n
);

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;     // 20 ns period
    end

    // Reset goes low on each request and is released 8 falling edges later
    initial
    begin
        arst_n = 1'b0;
        forever
        begin
            @(posedge rst_req);
            arst_n = 1'b0;
            repeat (8) @(negedge clk);
            arst_n = 1'b1;
        end
    end

endmodule

// File: hdl/rv_core.sv
`timescale 1ns/10ps

module rv_core #(
    parameter rv_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic          clk,
    input  logic          arst_n,
    output rv_pkg::word_t imem_addr,
    input  rv_pkg::word_t imem_data,
    output rv_pkg::word_t dmem_addr,
    output rv_pkg::word_t dmem_wdata,
    output rv_pkg::be_t   dmem_be,
    output logic          dmem_wr,
    output logic          dmem_rd,
    input  rv_pkg::word_t dmem_rdata
);

    rv_pkg::word_t pc;
    rv_pkg::word_t pc_next;
    rv_pkg::word_t pc_plus4;
    rv_pkg::word_t imm;
    rv_pkg::word_t rdata1;
    rv_pkg::word_t rdata2;
    rv_pkg::word_t alu_a;
    rv_pkg::word_t alu_b;
    rv_pkg::word_t alu_y;
    rv_pkg::word_t load_data;
    rv_pkg::word_t wb_data;
    logic          br_taken;
    logic          reg_we;

    ctrl_if ctl ();

    controller controller_inst (
        .opcode (imem_data[6:0]),
        .f3     (imem_data[14:12]),
        .f7     (imem_data[31:25]),
        .ctl    (ctl.dec)
    );

    imm_gen imm_gen_inst (
        .instr  (imem_data),
        .opcode (imem_data[6:0]),
        .imm    (imm)
    );

    reg_file reg_file_inst (
        .clk    (clk),
        .arst_n (arst_n),
        .rs1    (imem_data[19:15]),
        .rs2    (imem_data[24:20]),
        .rd     (imem_data[11:7]),
        .wdata  (wb_data),
        .we     (reg_we),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    assign alu_a = ctl.alu_s1 ? pc : rdata1;
    assign alu_b = ctl.alu_s2 ? imm : rdata2;

    alu alu_inst (
        .op (ctl.alu_op),
        .a  (alu_a),
        .b  (alu_b),
        .y  (alu_y)
    );

    branch_unit branch_unit_inst (
        .branch_ctrl (ctl.branch_ctrl),
        .a           (rdata1),
        .b           (rdata2),
        .taken       (br_taken)
    );

    lsu lsu_inst (
        .mem_ctrl   (ctl.mem_ctrl),
        .addr_lo    (alu_y[1:0]),
        .store_data (rdata2),
        .load_raw   (dmem_rdata),
        .be         (dmem_be),
        .wdata      (dmem_wdata),
        .load_data  (load_data)
    );

    assign pc_plus4 = pc + 32'd4;

    always_comb
    begin
        if (ctl.is_jalr)
            pc_next = {alu_y[31:1], 1'b0};
        else if (ctl.is_jump || br_taken)
            pc_next = pc + imm;         // jal or taken branch
        else
            pc_next = pc_plus4;
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            pc <= RESET_PC;
        else
            pc <= pc_next;
    end

    always_comb
    begin
        case (ctl.wb_sel)
            rv_pkg::WB_MEM: wb_data = load_data;
            rv_pkg::WB_PC4: wb_data = pc_plus4;
            default:        wb_data = alu_y;
        endcase
    end

    // No side effects while held in reset
    assign reg_we    = ctl.reg_wr & arst_n;
    assign dmem_wr   = ctl.mem_wr & arst_n;
    assign dmem_rd   = ctl.mem_rd & arst_n;
    assign dmem_addr = alu_y;
    assign imem_addr = pc;

endmodule

// File: hdl/lsu.sv
`timescale 1ns/10ps

module lsu (
    input  rv_pkg::mem_ctrl_e mem_ctrl,
    input  logic [1:0]        addr_lo,
    input  rv_pkg::word_t     store_data,
    input  rv_pkg::word_t     load_raw,
    output rv_pkg::be_t       be,
    output rv_pkg::word_t     wdata,
    output rv_pkg::word_t     load_data
);

    logic [7:0]  load_byte;
    logic [15:0] load_half;

    // Store side
    always_comb
    begin
        case (mem_ctrl)
            rv_pkg::MEM_SB:
            begin
                wdata = {4{store_data[7:0]}};
                be    = 4'b0001 << addr_lo;
            end
            rv_pkg::MEM_SH:
            begin
                wdata = {2{store_data[15:0]}};
                be    = addr_lo[1] ? 4'b1100 : 4'b0011;
            end
            rv_pkg::MEM_SW:
            begin
                wdata = store_data;
                be    = 4'b1111;
            end
            default:
            begin
                wdata = store_data;
                be    = 4'b0000;    // Loads write nothing
            end
        endcase
    end

    // Load lane select
    assign load_byte = load_raw[8*addr_lo +: 8];
    assign load_half = addr_lo[1] ? load_raw[31:16] : load_raw[15:0];

    always_comb
    begin
        case (mem_ctrl)
            rv_pkg::MEM_LB:  load_data = {{24{load_byte[7]}}, load_byte};
            rv_pkg::MEM_LBU: load_data = {24'b0, load_byte};
            rv_pkg::MEM_LH:  load_data = {{16{load_half[15]}}, load_half};
            rv_pkg::MEM_LHU: load_data = {16'b0, load_half};
            default:         load_data = load_raw;
        endcase
    end

endmodule

// File: hdl/branch_unit.sv
`timescale 1ns/10ps

module branch_unit (
    input  rv_pkg::br_ctrl_t branch_ctrl,
    input  rv_pkg::word_t    a,
    input  rv_pkg::word_t    b,
    output logic             taken
);

    always_comb
    begin
        case (branch_ctrl)
            3'b000:  taken = (a == b);                      // beq
            3'b001:  taken = (a != b);                      // bne
            3'b100:  taken = ($signed(a) < $signed(b));     // blt
            3'b101:  taken = ($signed(a) >= $signed(b));    // bge
            3'b110:  taken = (a < b);                       // bltu
            3'b111:  taken = (a >= b);                      // bgeu
            default: taken = 1'b0;
        endcase
    end

endmodule

// File: hdl/alu.sv
`timescale 1ns/10ps

module alu (
    input  rv_pkg::alu_op_e op,
    input  rv_pkg::word_t   a,
    input  rv_pkg::word_t   b,
    output rv_pkg::word_t   y
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb
    begin
        case (op)
            rv_pkg::ALU_ADD:  y = a + b;
            rv_pkg::ALU_SUB:  y = a - b;
            rv_pkg::ALU_SLL:  y = a << shamt;
            rv_pkg::ALU_SLT:  y = {31'b0, $signed(a) < $signed(b)};
            rv_pkg::ALU_SLTU: y = {31'b0, a < b};
            rv_pkg::ALU_XOR:  y = a ^ b;
            rv_pkg::ALU_SRL:  y = a >> shamt;
            rv_pkg::ALU_SRA:  y = rv_pkg::word_t'($signed(a) >>> shamt);
            rv_pkg::ALU_OR:   y = a | b;
            rv_pkg::ALU_AND:  y = a & b;
            default:          y = '0;   // nop
        endcase
    end

endmodule

// File: hdl/reg_file.sv
`timescale 1ns/10ps

module reg_file (
    input  logic             clk,
    input  logic             arst_n,
    input  rv_pkg::reg_idx_t rs1,
    input  rv_pkg::reg_idx_t rs2,
    input  rv_pkg::reg_idx_t rd,
    input  rv_pkg::word_t    wdata,
    input  logic             we,
    output rv_pkg::word_t    rdata1,
    output rv_pkg::word_t    rdata2
);

    rv_pkg::word_t regs [32];

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else if (we && rd != 5'd0)  // x0 stays zero
            regs[rd] <= wdata;
    end

    assign rdata1 = regs[rs1];
    assign rdata2 = regs[rs2];

endmodule

// File: hdl/imm_gen.sv
`timescale 1ns/10ps

module imm_gen (
    input  rv_pkg::word_t instr,
    input  logic [6:0]    opcode,
    output rv_pkg::word_t imm
);

    always_comb
    begin
        case (opcode)
            rv_pkg::OP_I, rv_pkg::OP_LOAD, rv_pkg::OP_JALR:
                imm = {{20{instr[31]}}, instr[31:20]};
            rv_pkg::OP_STORE:
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            rv_pkg::OP_BRANCH:
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            rv_pkg::OP_JAL:
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            default:
                imm = '0;
        endcase
    end

endmodule

// File: hdl/controller.sv
`timescale 1ns/10ps

module controller (
    input  logic [6:0] opcode,
    input  logic [2:0] f3,
    input  logic [6:0] f7,
    ctrl_if.dec        ctl
);

    always_comb
    begin
        ctl.reg_wr      = 1'b0;
        ctl.mem_rd      = 1'b0;
        ctl.mem_wr      = 1'b0;
        ctl.wb_sel      = rv_pkg::WB_MEM;
        ctl.alu_op      = rv_pkg::ALU_NOP;
        ctl.alu_s1      = 1'b0;
        ctl.alu_s2      = 1'b0;
        ctl.branch_ctrl = rv_pkg::BR_NEVER;
        ctl.is_jump     = 1'b0;
        ctl.is_jalr     = 1'b0;
        ctl.mem_ctrl    = rv_pkg::MEM_LB;
        case (opcode)
            rv_pkg::OP_R:
            begin
                ctl.reg_wr = 1'b1;
                ctl.wb_sel = rv_pkg::WB_ALU;
                case (f3)
                    3'b000:
                        ctl.alu_op = (f7 == 7'b0) ? rv_pkg::ALU_ADD : rv_pkg::ALU_SUB;
                    3'b101:
                        ctl.alu_op = (f7 == 7'b0) ? rv_pkg::ALU_SRL : rv_pkg::ALU_SRA;
                    default:
                    begin
                        if (f7 == 7'b0)
                            ctl.alu_op = rv_pkg::alu_op_e'({1'b0, f3});
                    end
                endcase
            end
            rv_pkg::OP_I:
            begin
                ctl.reg_wr = 1'b1;
                ctl.wb_sel = rv_pkg::WB_ALU;
                ctl.alu_s2 = 1'b1;
                if (f3 == 3'b101)
                    ctl.alu_op = (f7 == 7'b0) ? rv_pkg::ALU_SRL : rv_pkg::ALU_SRA;
                else
                    ctl.alu_op = rv_pkg::alu_op_e'({1'b0, f3});
            end
            rv_pkg::OP_LOAD:
            begin
                ctl.alu_op = rv_pkg::ALU_ADD;   // Address = rs1 + imm
                ctl.alu_s2 = 1'b1;
                ctl.reg_wr = 1'b1;
                ctl.mem_rd = 1'b1;
                case (f3)
                    3'b000:  ctl.mem_ctrl = rv_pkg::MEM_LB;
                    3'b001:  ctl.mem_ctrl = rv_pkg::MEM_LH;
                    3'b010:  ctl.mem_ctrl = rv_pkg::MEM_LW;
                    3'b100:  ctl.mem_ctrl = rv_pkg::MEM_LBU;
                    3'b101:  ctl.mem_ctrl = rv_pkg::MEM_LHU;
                    default:
                    begin
                        ctl.reg_wr = 1'b0;      // Undefined width, no-op
                        ctl.mem_rd = 1'b0;
                    end
                endcase
            end
            rv_pkg::OP_STORE:
            begin
                ctl.alu_op = rv_pkg::ALU_ADD;
                ctl.alu_s2 = 1'b1;
                ctl.mem_wr = 1'b1;
                case (f3)
                    3'b000:  ctl.mem_ctrl = rv_pkg::MEM_SB;
                    3'b001:  ctl.mem_ctrl = rv_pkg::MEM_SH;
                    3'b010:  ctl.mem_ctrl = rv_pkg::MEM_SW;
                    default: ctl.mem_wr   = 1'b0;
                endcase
            end
            rv_pkg::OP_BRANCH:
                ctl.branch_ctrl = f3;
            rv_pkg::OP_JAL:
            begin
                ctl.reg_wr  = 1'b1;
                ctl.wb_sel  = rv_pkg::WB_PC4;
                ctl.alu_op  = rv_pkg::ALU_ADD;
                ctl.alu_s1  = 1'b1;
                ctl.alu_s2  = 1'b1;
                ctl.is_jump = 1'b1;
            end
            rv_pkg::OP_JALR:
            begin
                ctl.reg_wr  = 1'b1;
                ctl.wb_sel  = rv_pkg::WB_PC4;
                ctl.alu_op  = rv_pkg::ALU_ADD;  // Target = rs1 + imm
                ctl.alu_s2  = 1'b1;
                ctl.is_jump = 1'b1;
                ctl.is_jalr = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// File: hdl/ctrl_if.sv
`timescale 1ns/10ps

interface ctrl_if;
    logic               reg_wr;
    logic               mem_rd;
    logic               mem_wr;
    rv_pkg::wb_sel_e    wb_sel;
    rv_pkg::alu_op_e    alu_op;
    logic               alu_s1;     // Operand A is the PC
    logic               alu_s2;     // Operand B is the immediate
    rv_pkg::br_ctrl_t   branch_ctrl;
    logic               is_jump;
    logic               is_jalr;
    rv_pkg::mem_ctrl_e  mem_ctrl;

    modport dec (output reg_wr, mem_rd, mem_wr, wb_sel, alu_op, alu_s1, alu_s2,
                 branch_ctrl, is_jump, is_jalr, mem_ctrl);
    modport dp  (input  reg_wr, mem_rd, mem_wr, wb_sel, alu_op, alu_s1, alu_s2,
                 branch_ctrl, is_jump, is_jalr, mem_ctrl);
endinterface

// File: hdl/rv_pkg.sv
package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [3:0]  be_t;
    typedef logic [2:0]  br_ctrl_t; // funct3 of a branch

    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SLL  = 4'b0001,
        ALU_SLT  = 4'b0010,
        ALU_SLTU = 4'b0011,
        ALU_XOR  = 4'b0100,
        ALU_SRL  = 4'b0101,
        ALU_OR   = 4'b0110,
        ALU_AND  = 4'b0111,
        ALU_SUB  = 4'b1000,
        ALU_SRA  = 4'b1101,
        ALU_NOP  = 4'b1111
    } alu_op_e;

    typedef enum logic [2:0] {
        MEM_LB  = 3'b000,
        MEM_LH  = 3'b001,
        MEM_LW  = 3'b010,
        MEM_LBU = 3'b011,
        MEM_LHU = 3'b100,
        MEM_SB  = 3'b101,
        MEM_SH  = 3'b110,
        MEM_SW  = 3'b111
    } mem_ctrl_e;

    typedef enum logic [1:0] {
        WB_MEM = 2'b00,
        WB_ALU = 2'b01,
        WB_PC4 = 2'b10
    } wb_sel_e;

    localparam br_ctrl_t BR_NEVER = 3'b011;

    localparam logic [6:0] OP_R      = 7'b0110011;
    localparam logic [6:0] OP_I      = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;

endpackage
